/* run.sh */
#!/bin/sh
# Build and run the core memory testbench with Verilator

verilator --binary --timing --assert -f tb.f --top-module core_mem_tb -o core_mem_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/core_mem_sim +verilator+error+limit+100 > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

if grep -q "^ALL CHECKS PASSED$" sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1

/* tb.f */
+incdir+tests
verilog/l1_pkg.sv
verilog/l1_cache.sv
verilog/store_buffer.sv
verilog/l2req_arbiter.sv
verilog/core_mem.sv
tests/core_mem_chk.sv
tests/core_mem_scoreboard.sv
tests/core_mem_tb.sv

/* tests/core_mem_chk.sv */
// Assertions holding the L2 port and every requester packet stable until taken
module core_mem_chk
	(input clk,
	input reset,
	input l1_pkg::l2req_packet_t l2req_i,
	input l2req_ready_i,
	input l1_pkg::l2req_packet_t icache_req_i,
	input l1_pkg::l2req_packet_t dcache_req_i,
	input l1_pkg::l2req_packet_t stbuf_req_i,
	input icache_ready_i,
	input dcache_ready_i,
	input stbuf_ready_i);

	int fails = 0;

	// Offered packet waits unchanged for L2
	hold_stable: assert property (@(posedge clk) disable iff (reset)
		l2req_i.valid && !l2req_ready_i |=> l2req_i.valid && $stable(l2req_i))
	else
	begin
		$error("L2 request changed or dropped while L2 was not ready");
		fails++;
	end

	// Requesters keep their packet until the arbiter grants it
	icache_hold: assert property (@(posedge clk) disable iff (reset)
		icache_req_i.valid && !icache_ready_i |=> icache_req_i.valid && $stable(icache_req_i))
	else
	begin
		$error("Icache request changed or dropped before it was granted");
		fails++;
	end

	dcache_hold: assert property (@(posedge clk) disable iff (reset)
		dcache_req_i.valid && !dcache_ready_i |=> dcache_req_i.valid && $stable(dcache_req_i))
	else
	begin
		$error("Dcache request changed or dropped before it was granted");
		fails++;
	end

	stbuf_hold: assert property (@(posedge clk) disable iff (reset)
		stbuf_req_i.valid && !stbuf_ready_i |=> stbuf_req_i.valid && $stable(stbuf_req_i))
	else
	begin
		$error("Store buffer request changed or dropped before it was granted");
		fails++;
	end
endmodule

bind l2req_arbiter core_mem_chk chk_i (
	.clk(clk),
	.reset(reset),
	.l2req_i(l2req_o),
	.l2req_ready_i(l2req_ready_i),
	.icache_req_i(icache_req_i),
	.dcache_req_i(dcache_req_i),
	.stbuf_req_i(stbuf_req_i),
	.icache_ready_i(icache_ready_o),
	.dcache_ready_i(dcache_ready_o),
	.stbuf_ready_i(stbuf_ready_o));

/* tests/core_mem_tb_defs.svh */
// Shared testbench step kinds and the initial L2 memory pattern
localparam logic [3:0] K_RESET = 4'd0;		// Outputs low after reset
localparam logic [3:0] K_HIT = 4'd1;		// Data load must hit
localparam logic [3:0] K_MISS = 4'd2;
localparam logic [3:0] K_COLL = 4'd3;		// Miss behind a pending fill
localparam logic [3:0] K_ANY = 4'd4;		// Load, hit optional
localparam logic [3:0] K_STORE = 4'd5;
localparam logic [3:0] K_ROLL = 4'd6;		// Store into a full slot
localparam logic [3:0] K_FHIT = 4'd7;
localparam logic [3:0] K_FMISS = 4'd8;
localparam logic [3:0] W_LOAD = 4'd9;		// Wait for load_complete_o
localparam logic [3:0] W_FETCH = 4'd10;
localparam logic [3:0] W_RESUME = 4'd11;

// Every word differs, built from the full line address and lane
function automatic line_t mem_pattern(line_addr_t a);
	line_t l;

	for (int w = 0; w < 4; w++)
		l[w * 32 +: 32] = {a, 2'(w), 2'b00} ^ 32'h6b1d_93c5;
	return l;
endfunction

/* tests/core_mem_scoreboard.sv */
// Scoreboard comparing core memory outputs with a private memory image and store copy
module core_mem_scoreboard
	(input clk,
	input check_i,
	input int test_i,
	input logic [3:0] kind_i,
	input l1_pkg::strand_t strand_i,
	input logic [29:0] addr_i,
	input l1_pkg::line_t data_i,
	input l1_pkg::mask_t mask_i,
	input fetch_hit_i,
	input [31:0] fetch_data_i,
	input [l1_pkg::STRANDS - 1:0] fetch_complete_i,
	input load_hit_i,
	input load_collision_i,
	input l1_pkg::line_t load_data_i,
	input [l1_pkg::STRANDS - 1:0] load_complete_i,
	input store_rollback_i,
	input [l1_pkg::STRANDS - 1:0] store_resume_i,
	input l2req_valid_i,
	input l1_pkg::l2rsp_packet_t l2rsp_i,
	output int errors_o);

	import l1_pkg::*;
	`include "core_mem_tb_defs.svh"

	line_t image [line_addr_t];		// Lines written by completed stores
	logic [STRANDS - 1:0] pend_valid = '0;
	line_addr_t pend_addr [STRANDS];
	line_t pend_data [STRANDS];
	mask_t pend_mask [STRANDS];
	int err_count = 0;
	int test_errors;

	assign errors_o = err_count;

	function automatic line_t mem_line(line_addr_t a);
		return image.exists(a) ? image[a] : mem_pattern(a);
	endfunction

	function automatic line_t overlay(line_t base, line_t data, mask_t mask);
		line_t l;

		l = base;
		for (int b = 0; b < LINE_BYTES; b++)
			if (mask[b])
				l[b * 8 +: 8] = data[b * 8 +: 8];
		return l;
	endfunction

	// Memory line plus own strand's pending bytes
	function automatic line_t expect_load(strand_t s, line_addr_t a);
		line_t l;

		l = mem_line(a);
		if (pend_valid[s] && pend_addr[s] == a)
			l = overlay(l, pend_data[s], pend_mask[s]);
		return l;
	endfunction

	task automatic check_bit(string name, logic got, logic exp);
		if (got !== exp)
		begin
			$display("Mismatch in test %0d: %s got %h expected %h", test_i, name, got, exp);
			test_errors++;
		end
	endtask

	task automatic check_vec(string name, logic [127:0] got, logic [127:0] exp);
		if (got !== exp)
		begin
			$display("Mismatch in test %0d: %s got %h expected %h", test_i, name, got, exp);
			test_errors++;
		end
	endtask

	always @(negedge clk)
	begin
		line_t fline;
		strand_t rs;

		if (check_i)
		begin
			test_errors = 0;
			fline = mem_line(addr_i[29:2]);
			case (kind_i)
				K_RESET:
				begin
					check_bit("fetch_hit_o", fetch_hit_i, 1'b0);
					check_vec("fetch_complete_o", 128'(fetch_complete_i), '0);
					check_bit("load_hit_o", load_hit_i, 1'b0);
					check_bit("load_collision_o", load_collision_i, 1'b0);
					check_vec("load_complete_o", 128'(load_complete_i), '0);
					check_bit("store_rollback_o", store_rollback_i, 1'b0);
					check_vec("store_resume_o", 128'(store_resume_i), '0);
					check_bit("l2req_o.valid", l2req_valid_i, 1'b0);
				end
				K_HIT:
				begin
					check_bit("load_hit_o", load_hit_i, 1'b1);
					check_vec("load_data_o", load_data_i, expect_load(strand_i, addr_i[27:0]));
				end
				K_MISS:
				begin
					check_bit("load_hit_o", load_hit_i, 1'b0);
					check_bit("load_collision_o", load_collision_i, 1'b0);
				end
				K_COLL:
					check_bit("load_collision_o", load_collision_i, 1'b1);
				K_ANY:
					if (load_hit_i)
						check_vec("load_data_o", load_data_i, expect_load(strand_i, addr_i[27:0]));
				K_STORE:
				begin
					check_bit("store_rollback_o", store_rollback_i, 1'b0);
					pend_valid[strand_i] = 1'b1;	// Slot now holds this store
					pend_addr[strand_i] = addr_i[27:0];
					pend_data[strand_i] = data_i;
					pend_mask[strand_i] = mask_i;
				end
				K_ROLL:
					check_bit("store_rollback_o", store_rollback_i, 1'b1);
				K_FHIT:
				begin
					check_bit("fetch_hit_o", fetch_hit_i, 1'b1);
					check_vec("fetch_data_o", 128'(fetch_data_i),
						128'(fline[addr_i[1:0] * 32 +: 32]));
				end
				K_FMISS:
					check_bit("fetch_hit_o", fetch_hit_i, 1'b0);
				default:
				begin
					$display("Test %0d has an unknown step kind %0d", test_i, kind_i);
					test_errors++;
				end
			endcase
			err_count += test_errors;
			if (test_errors == 0)
				$display("Test %0d passed", test_i);
			else
				$display("Test %0d failed with %0d errors", test_i, test_errors);
		end

		// Store response lands in memory after this cycle's compare
		rs = l2rsp_i.strand;
		if (l2rsp_i.valid && l2rsp_i.op == L2_STORE && l2rsp_i.unit == UNIT_STBUF
			&& pend_valid[rs])
		begin
			image[pend_addr[rs]] = overlay(mem_line(pend_addr[rs]), pend_data[rs],
				pend_mask[rs]);
			pend_valid[rs] = 1'b0;
		end
	end
endmodule

/* tests/core_mem_tb.sv */
// Testbench for the core memory side with L2 memory model, stimulus table and watchdog
module core_mem_tb;
	import l1_pkg::*;
	`include "core_mem_tb_defs.svh"

	typedef struct packed {
		logic [3:0] kind;
		strand_t strand;
		logic [29:0] addr;		// Line address for data ops, word address for fetches
		logic [7:0] pat;		// Store byte, repeated over the line
		mask_t mask;
	} step_t;

	logic clk;
	logic reset;
	logic fetch_i;
	word_addr_t fetch_addr_i;
	logic fetch_hit_o;
	logic [31:0] fetch_data_o;
	logic [STRANDS - 1:0] fetch_complete_o;
	logic load_i;
	logic store_i;
	line_addr_t addr_i;
	strand_t strand_i;
	line_t store_data_i;
	mask_t store_mask_i;
	logic load_hit_o;
	logic load_collision_o;
	line_t load_data_o;
	logic [STRANDS - 1:0] load_complete_o;
	logic store_rollback_o;
	logic [STRANDS - 1:0] store_resume_o;
	l2req_packet_t l2req_o;
	logic l2req_ready_i;
	l2rsp_packet_t l2rsp_i;

	step_t steps [$];
	step_t cur;
	int test_idx = 0;
	logic check = 1'b0;
	logic table_ready = 1'b0;
	int cyc = 0;
	int tb_errors = 0;
	int sb_errors;
	int total;
	int req_count = 0;
	int exp_req = 0;		// Requests the table should cause

	// L2 model state
	line_t l2_mem [line_addr_t];
	l2req_packet_t pend_pkt [$];
	int pend_due [$];
	logic took = 1'b0;
	l2req_packet_t took_pkt;

	// Sticky completion flags, cleared when a wait step consumes them
	logic [STRANDS - 1:0] load_seen = '0;
	logic [STRANDS - 1:0] fetch_seen = '0;
	logic [STRANDS - 1:0] resume_seen = '0;

	core_mem dut_i (.*);

	core_mem_scoreboard sb_i (
		.clk(clk),
		.check_i(check),
		.test_i(test_idx),
		.kind_i(cur.kind),
		.strand_i(cur.strand),
		.addr_i(cur.addr),
		.data_i({16{cur.pat}}),
		.mask_i(cur.mask),
		.fetch_hit_i(fetch_hit_o),
		.fetch_data_i(fetch_data_o),
		.fetch_complete_i(fetch_complete_o),
		.load_hit_i(load_hit_o),
		.load_collision_i(load_collision_o),
		.load_data_i(load_data_o),
		.load_complete_i(load_complete_o),
		.store_rollback_i(store_rollback_o),
		.store_resume_i(store_resume_o),
		.l2req_valid_i(l2req_o.valid),
		.l2rsp_i(l2rsp_i),
		.errors_o(sb_errors));

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk)
		cyc <= cyc + 1;

	function automatic line_t read_mem(line_addr_t a);
		return l2_mem.exists(a) ? l2_mem[a] : mem_pattern(a);
	endfunction

	// One-cycle response, stores merge by mask
	task automatic respond(l2req_packet_t p);
		line_t old;

		old = read_mem(p.address);
		l2rsp_i.valid = 1'b1;
		l2rsp_i.op = p.op;
		l2rsp_i.unit = p.unit;
		l2rsp_i.strand = p.strand;
		l2rsp_i.address = p.address;
		if (p.op == L2_STORE)
		begin
			for (int b = 0; b < LINE_BYTES; b++)
				if (p.mask[b])
					old[b * 8 +: 8] = p.data[b * 8 +: 8];
			l2_mem[p.address] = old;
			l2rsp_i.data = '0;
		end
		else
			l2rsp_i.data = old;
	endtask

	// Handshake seen mid-cycle, completed at the next edge
	always @(negedge clk)
	begin
		took = l2req_o.valid && l2req_ready_i;
		took_pkt = l2req_o;
		load_seen = load_seen | load_complete_o;
		fetch_seen = fetch_seen | fetch_complete_o;
		resume_seen = resume_seen | store_resume_o;
	end

	always @(posedge clk)
	begin
		#1;
		if (took)
		begin
			pend_pkt.push_back(took_pkt);
			pend_due.push_back(cyc + int'($urandom_range(6, 1)));	// 1 to 6 cycles
			req_count++;
		end
		l2rsp_i = '0;
		if (pend_pkt.size() > 0 && pend_due[0] <= cyc)
		begin
			respond(pend_pkt.pop_front());
			void'(pend_due.pop_front());
		end
		l2req_ready_i = $urandom_range(3, 0) != 0;	// Low about a quarter of cycles
	end

	task automatic add(logic [3:0] kind, strand_t s, logic [29:0] a, logic [7:0] pat, mask_t m);
		step_t st;

		st.kind = kind;
		st.strand = s;
		st.addr = a;
		st.pat = pat;
		st.mask = m;
		steps.push_back(st);
	endtask

	task automatic wait_completion(int idx, logic [3:0] which, strand_t s, logic report);
		int n;
		logic seen;

		n = 0;
		seen = 1'b0;
		while (!seen && n < 40)
		begin
			@(negedge clk);
			#1;
			case (which)
				W_LOAD: seen = load_seen[s];
				W_FETCH: seen = fetch_seen[s];
				default: seen = resume_seen[s];
			endcase
			n++;
		end
		if (seen)
		begin
			case (which)
				W_LOAD: load_seen[s] = 1'b0;
				W_FETCH: fetch_seen[s] = 1'b0;
				default: resume_seen[s] = 1'b0;
			endcase
			if (report)
				$display("Test %0d passed", idx);
		end
		else
		begin
			$display("Test %0d: strand %0d saw no completion pulse within 40 cycles", idx, s);
			tb_errors++;
		end
	endtask

	task automatic run_step(int idx, step_t st);
		@(posedge clk);
		#1;
		test_idx = idx;
		cur = st;
		if (st.kind >= W_LOAD)
		begin
			wait_completion(idx, st.kind, st.strand, 1'b1);
			return;
		end
		addr_i = st.addr[27:0];
		strand_i = st.strand;
		store_data_i = {16{st.pat}};
		store_mask_i = st.mask;
		fetch_addr_i = st.addr;
		load_i = st.kind inside {K_HIT, K_MISS, K_COLL, K_ANY};
		store_i = st.kind inside {K_STORE, K_ROLL};
		fetch_i = st.kind inside {K_FHIT, K_FMISS};
		if (st.kind inside {K_MISS, K_FMISS, K_STORE})
			exp_req++;		// One L2 request per plain miss or accepted store
		@(posedge clk);
		#1;
		load_i = 1'b0;
		store_i = 1'b0;
		fetch_i = 1'b0;
		check = 1'b1;		// Scoreboard compares at the falling edge
		@(negedge clk);
		#1;
		check = 1'b0;
		if (st.kind == K_ANY && !load_hit_o)
		begin
			exp_req++;
			wait_completion(idx, W_LOAD, st.strand, 1'b0);
		end
	endtask

	initial
	begin
		int n;

		void'($urandom(32'ha94c_eda0));
		reset = 1'b1;
		fetch_i = 1'b0;
		fetch_addr_i = '0;
		load_i = 1'b0;
		store_i = 1'b0;
		addr_i = '0;
		strand_i = '0;
		store_data_i = '0;
		store_mask_i = '0;
		l2req_ready_i = 1'b0;
		l2rsp_i = '0;
		cur = '0;

		add(K_RESET, 2'd0, 30'h0, 8'h00, 16'h0000);
		add(K_MISS, 2'd1, 30'h10, 8'h00, 16'h0000);		// Miss, collide, fill, hit
		add(K_COLL, 2'd2, 30'h21, 8'h00, 16'h0000);
		add(W_LOAD, 2'd1, 30'h0, 8'h00, 16'h0000);
		add(K_HIT, 2'd1, 30'h10, 8'h00, 16'h0000);
		add(K_MISS, 2'd2, 30'h21, 8'h00, 16'h0000);
		add(W_LOAD, 2'd2, 30'h0, 8'h00, 16'h0000);
		add(K_HIT, 2'd2, 30'h21, 8'h00, 16'h0000);
		add(K_STORE, 2'd0, 30'h10, 8'h3c, 16'h00f0);	// Bypass onto a cached line
		add(K_HIT, 2'd0, 30'h10, 8'h00, 16'h0000);
		add(K_ANY, 2'd3, 30'h10, 8'h00, 16'h0000);
		add(W_RESUME, 2'd0, 30'h0, 8'h00, 16'h0000);
		add(K_MISS, 2'd2, 30'h32, 8'h00, 16'h0000);		// Rollback and invalidate
		add(W_LOAD, 2'd2, 30'h0, 8'h00, 16'h0000);
		add(K_STORE, 2'd2, 30'h32, 8'ha5, 16'hff00);
		add(K_ROLL, 2'd2, 30'h32, 8'h11, 16'hffff);
		add(W_RESUME, 2'd2, 30'h0, 8'h00, 16'h0000);
		add(K_MISS, 2'd2, 30'h32, 8'h00, 16'h0000);
		add(W_LOAD, 2'd2, 30'h0, 8'h00, 16'h0000);
		add(K_HIT, 2'd2, 30'h32, 8'h00, 16'h0000);
		add(K_FMISS, 2'd0, {28'h43, 2'd2}, 8'h00, 16'h0000);
		add(W_FETCH, 2'd0, 30'h0, 8'h00, 16'h0000);
		add(K_FHIT, 2'd0, {28'h43, 2'd2}, 8'h00, 16'h0000);
		add(K_FHIT, 2'd0, {28'h43, 2'd1}, 8'h00, 16'h0000);
		add(K_STORE, 2'd1, 30'h55, 8'h9e, 16'h0001);	// Two strands storing at once
		add(K_STORE, 2'd3, 30'h66, 8'h47, 16'h8000);
		add(W_RESUME, 2'd1, 30'h0, 8'h00, 16'h0000);
		add(W_RESUME, 2'd3, 30'h0, 8'h00, 16'h0000);
		add(K_MISS, 2'd1, 30'h55, 8'h00, 16'h0000);
		add(W_LOAD, 2'd1, 30'h0, 8'h00, 16'h0000);
		add(K_HIT, 2'd1, 30'h55, 8'h00, 16'h0000);
		table_ready = 1'b1;

		repeat (4) @(posedge clk);
		#1 reset = 1'b0;

		foreach (steps[i])
			run_step(i, steps[i]);

		// Let the L2 side drain
		n = 0;
		while ((pend_pkt.size() != 0 || l2req_o.valid) && n < 40)
		begin
			@(posedge clk);
			n++;
		end
		if (pend_pkt.size() != 0 || l2req_o.valid)
		begin
			$display("L2 requests still outstanding after the last test");
			tb_errors++;
		end
		if (req_count != exp_req)
		begin
			$display("L2 took %0d requests but the tests should send %0d", req_count, exp_req);
			tb_errors++;
		end

		total = sb_errors + tb_errors + dut_i.arbiter.chk_i.fails;
		$display("Tests: %0d, L2 requests: %0d, errors: %0d", steps.size(), req_count, total);
		if (total == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	// Watchdog, 40 cycles per step
	initial
	begin
		wait (table_ready);
		#((steps.size() * 40 + 10) * 100);
		$display("Watchdog expired before the tests finished");
		$display("CHECKS FAILED");
		$finish;
	end
endmodule

/* verilog/core_mem.sv */
// Core memory side joining I/D caches, store buffer, L2 arbiter and fetch word select
module core_mem
	(input clk,
	input reset,
	input fetch_i,
	input l1_pkg::word_addr_t fetch_addr_i,
	output logic fetch_hit_o,
	output logic [31:0] fetch_data_o,
	output logic [l1_pkg::STRANDS - 1:0] fetch_complete_o,
	input load_i,
	input store_i,
	input l1_pkg::line_addr_t addr_i,
	input l1_pkg::strand_t strand_i,
	input l1_pkg::line_t store_data_i,
	input l1_pkg::mask_t store_mask_i,
	output logic load_hit_o,
	output logic load_collision_o,
	output l1_pkg::line_t load_data_o,
	output logic [l1_pkg::STRANDS - 1:0] load_complete_o,
	output logic store_rollback_o,
	output logic [l1_pkg::STRANDS - 1:0] store_resume_o,
	output l1_pkg::l2req_packet_t l2req_o,
	input l2req_ready_i,
	input l1_pkg::l2rsp_packet_t l2rsp_i);

	import l1_pkg::*;

	l2req_packet_t icache_req;
	l2req_packet_t dcache_req;
	l2req_packet_t stbuf_req;
	logic icache_ready;
	logic dcache_ready;
	logic stbuf_ready;
	line_t icache_line;
	line_t dcache_line;
	logic [1:0] fetch_lane_r;	// Word within the line

	// Instruction side, single fetch thread
	l1_cache #(.UNIT(UNIT_ICACHE)) icache (
		.clk(clk),
		.reset(reset),
		.access_i(fetch_i),
		.addr_i(fetch_addr_i[$bits(word_addr_t) - 1:2]),
		.strand_i(strand_t'(0)),
		.data_o(icache_line),
		.hit_o(fetch_hit_o),
		.collision_o(),			// Fetch retries on complete only
		.load_complete_o(fetch_complete_o),
		.l2req_o(icache_req),
		.l2req_ready_i(icache_ready),
		.l2rsp_i(l2rsp_i),
		.inval_en_i(1'b0));		// Code is never stored to

	always_ff @(posedge clk)
		fetch_lane_r <= fetch_addr_i[1:0];

	assign fetch_data_o = icache_line[fetch_lane_r * 32 +: 32];	// Lane 0 at the low end

	l1_cache #(.UNIT(UNIT_DCACHE)) dcache (
		.clk(clk),
		.reset(reset),
		.access_i(load_i),
		.addr_i(addr_i),
		.strand_i(strand_i),
		.data_o(dcache_line),
		.hit_o(load_hit_o),
		.collision_o(load_collision_o),
		.load_complete_o(load_complete_o),
		.l2req_o(dcache_req),
		.l2req_ready_i(dcache_ready),
		.l2rsp_i(l2rsp_i),
		.inval_en_i(1'b1));		// Write through, drop line on store completion

	// Overlays pending store bytes on the dcache line
	store_buffer stbuf (
		.clk(clk),
		.reset(reset),
		.store_i(store_i),
		.load_i(load_i),
		.addr_i(addr_i),
		.strand_i(strand_i),
		.data_i(store_data_i),
		.mask_i(store_mask_i),
		.cache_data_i(dcache_line),
		.data_o(load_data_o),
		.rollback_o(store_rollback_o),
		.resume_o(store_resume_o),
		.l2req_o(stbuf_req),
		.l2req_ready_i(stbuf_ready),
		.l2rsp_i(l2rsp_i));

	l2req_arbiter arbiter (
		.clk(clk),
		.reset(reset),
		.icache_req_i(icache_req),
		.dcache_req_i(dcache_req),
		.stbuf_req_i(stbuf_req),
		.icache_ready_o(icache_ready),
		.dcache_ready_o(dcache_ready),
		.stbuf_ready_o(stbuf_ready),
		.l2req_o(l2req_o),
		.l2req_ready_i(l2req_ready_i));
endmodule

/* verilog/l1_cache.sv */
// L1 cache, direct mapped, one outstanding miss filled from L2, optional store invalidate
module l1_cache
	#(parameter l1_pkg::unit_t UNIT = l1_pkg::UNIT_ICACHE)
	(input clk,
	input reset,
	input access_i,
	input l1_pkg::line_addr_t addr_i,
	input l1_pkg::strand_t strand_i,
	output l1_pkg::line_t data_o,
	output logic hit_o,
	output logic collision_o,
	output logic [l1_pkg::STRANDS - 1:0] load_complete_o,
	output l1_pkg::l2req_packet_t l2req_o,
	input l2req_ready_i,
	input l1_pkg::l2rsp_packet_t l2rsp_i,
	input inval_en_i);

	import l1_pkg::*;

	// Arrays
	line_t data_mem [SETS];
	tag_t tag_mem [SETS];
	logic [SETS - 1:0] valid_bits;

	// Registered lookup
	logic access_r;
	line_addr_t addr_r;
	strand_t strand_r;

	// Miss tracking
	fill_state_t state;
	line_addr_t fill_addr;
	strand_t fill_strand;
	logic req_valid;		// Miss request not yet taken by arbiter

	set_t lookup_set;
	tag_t lookup_tag;
	set_t fill_set;
	tag_t fill_tag;
	set_t rsp_set;
	tag_t rsp_tag;
	logic miss;
	logic fill_en;
	logic inval_hit;

	assign lookup_set = addr_r[$bits(set_t) - 1:0];
	assign lookup_tag = addr_r[$bits(line_addr_t) - 1:$bits(set_t)];
	assign fill_set = fill_addr[$bits(set_t) - 1:0];
	assign fill_tag = fill_addr[$bits(line_addr_t) - 1:$bits(set_t)];
	assign rsp_set = l2rsp_i.address[$bits(set_t) - 1:0];
	assign rsp_tag = l2rsp_i.address[$bits(line_addr_t) - 1:$bits(set_t)];

	// Tag compare on the registered address
	assign hit_o = access_r && valid_bits[lookup_set] && tag_mem[lookup_set] == lookup_tag;
	assign miss = access_r && !hit_o;
	assign collision_o = miss && state == WAIT_FILL;	// Only one miss at a time
	assign data_o = data_mem[lookup_set];

	// Our own fill returning
	assign fill_en = state == WAIT_FILL && l2rsp_i.valid && l2rsp_i.op == L2_LOAD
		&& l2rsp_i.unit == UNIT && l2rsp_i.strand == fill_strand;

	// Any store that reached L2 makes our copy stale
	assign inval_hit = inval_en_i && l2rsp_i.valid && l2rsp_i.op == L2_STORE
		&& valid_bits[rsp_set] && tag_mem[rsp_set] == rsp_tag;

	always_comb
	begin
		l2req_o = '0;
		l2req_o.valid = req_valid;
		l2req_o.op = L2_LOAD;
		l2req_o.unit = UNIT;
		l2req_o.strand = fill_strand;
		l2req_o.address = fill_addr;
	end

	// Line data and tag written at the fill edge
	always_ff @(posedge clk)
	begin
		if (fill_en)
		begin
			data_mem[fill_set] <= l2rsp_i.data;
			tag_mem[fill_set] <= fill_tag;
		end
	end

	always_ff @(posedge clk)
	begin
		addr_r <= addr_i;
		strand_r <= strand_i;
		if (state == IDLE && miss)
		begin
			fill_addr <= addr_r;	// Captured with the miss
			fill_strand <= strand_r;
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			access_r <= 1'b0;
			valid_bits <= '0;
			state <= IDLE;
			req_valid <= 1'b0;
			load_complete_o <= '0;
		end
		else
		begin
			access_r <= access_i;
			load_complete_o <= '0;
			if (fill_en)
				valid_bits[fill_set] <= 1'b1;
			else if (inval_hit)
				valid_bits[rsp_set] <= 1'b0;

			case (state)
				IDLE:
				begin
					if (miss)
					begin
						state <= WAIT_FILL;
						req_valid <= 1'b1;
					end
				end

				WAIT_FILL:
				begin
					if (req_valid && l2req_ready_i)
						req_valid <= 1'b0;	// Arbiter took it

					if (fill_en)
					begin
						state <= IDLE;
						load_complete_o[fill_strand] <= 1'b1;	// Wakes the strand
					end
				end
			endcase
		end
	end
endmodule

/* verilog/l1_pkg.sv */
// L1 memory package with widths, requester codes, L2 packet formats and fill states
package l1_pkg;
	localparam int STRANDS = 4;		// Hardware threads per core
	localparam int LINE_BYTES = 16;
	localparam int SETS = 8;		// Direct mapped, one line per set

	typedef logic [$clog2(STRANDS) - 1:0] strand_t;
	typedef logic [LINE_BYTES * 8 - 1:0] line_t;
	typedef logic [LINE_BYTES - 1:0] mask_t;		// One bit per byte of a line
	typedef logic [27:0] line_addr_t;				// Byte address minus line offset
	typedef logic [29:0] word_addr_t;
	typedef logic [$clog2(SETS) - 1:0] set_t;
	typedef logic [$bits(line_addr_t) - $bits(set_t) - 1:0] tag_t;

	// Requester codes, also the arbiter input index
	typedef logic [1:0] unit_t;
	localparam unit_t UNIT_ICACHE = 2'd0;
	localparam unit_t UNIT_DCACHE = 2'd1;
	localparam unit_t UNIT_STBUF = 2'd2;

	typedef logic l2_op_t;
	localparam l2_op_t L2_LOAD = 1'b0;
	localparam l2_op_t L2_STORE = 1'b1;

	// Held by the sender until ready
	typedef struct packed {
		logic valid;
		l2_op_t op;
		unit_t unit;
		strand_t strand;
		line_addr_t address;
		mask_t mask;			// Store byte enables
		line_t data;			// Store data
	} l2req_packet_t;

	// Broadcast to every unit, valid for one cycle
	typedef struct packed {
		logic valid;
		l2_op_t op;
		unit_t unit;
		strand_t strand;
		line_addr_t address;
		line_t data;			// Fill line on loads only
	} l2rsp_packet_t;

	typedef enum logic {
		IDLE,
		WAIT_FILL
	} fill_state_t;
endpackage

/* verilog/l2req_arbiter.sv */
// L2 request arbiter, round robin over three units into one registered output
module l2req_arbiter
	(input clk,
	input reset,
	input l1_pkg::l2req_packet_t icache_req_i,
	input l1_pkg::l2req_packet_t dcache_req_i,
	input l1_pkg::l2req_packet_t stbuf_req_i,
	output logic icache_ready_o,
	output logic dcache_ready_o,
	output logic stbuf_ready_o,
	output l1_pkg::l2req_packet_t l2req_o,
	input l2req_ready_i);

	import l1_pkg::*;

	l2req_packet_t req_pkt [UNIT_ICACHE:UNIT_STBUF];	// Indexed by unit code
	l2req_packet_t out_pkt;
	logic out_valid;
	unit_t rr_ptr;
	unit_t grant;
	logic grant_valid;
	logic can_accept;
	logic take;

	assign req_pkt[UNIT_ICACHE] = icache_req_i;
	assign req_pkt[UNIT_DCACHE] = dcache_req_i;
	assign req_pkt[UNIT_STBUF] = stbuf_req_i;

	// Empty or draining this cycle
	assign can_accept = !out_valid || l2req_ready_i;

	always_comb
	begin
		logic [2:0] sum;

		grant_valid = 1'b0;
		grant = rr_ptr;
		for (int off = int'(UNIT_STBUF); off >= 0; off--)
		begin
			sum = {1'b0, rr_ptr} + 3'(off);
			if (sum > 3'(UNIT_STBUF))
				sum = sum - (3'(UNIT_STBUF) + 3'd1);	// Wrap over three units
			if (req_pkt[unit_t'(sum)].valid)
			begin
				grant_valid = 1'b1;
				grant = unit_t'(sum);
			end
		end
	end

	assign take = can_accept && grant_valid;
	assign icache_ready_o = take && grant == UNIT_ICACHE;
	assign dcache_ready_o = take && grant == UNIT_DCACHE;
	assign stbuf_ready_o = take && grant == UNIT_STBUF;

	always_comb
	begin
		l2req_o = out_pkt;
		l2req_o.valid = out_valid;
	end

	always_ff @(posedge clk)
	begin
		if (take)
			out_pkt <= req_pkt[grant];
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			out_valid <= 1'b0;
			rr_ptr <= UNIT_ICACHE;
		end
		else if (can_accept)
		begin
			out_valid <= grant_valid;
			if (grant_valid)
				rr_ptr <= grant == UNIT_STBUF ? UNIT_ICACHE : grant + 2'd1;	// Next after winner
		end
	end
endmodule

/* verilog/store_buffer.sv */
// Store buffer with one pending store per strand, L2 write issue and load byte bypass
module store_buffer
	(input clk,
	input reset,
	input store_i,
	input load_i,
	input l1_pkg::line_addr_t addr_i,
	input l1_pkg::strand_t strand_i,
	input l1_pkg::line_t data_i,
	input l1_pkg::mask_t mask_i,
	input l1_pkg::line_t cache_data_i,
	output l1_pkg::line_t data_o,
	output logic rollback_o,
	output logic [l1_pkg::STRANDS - 1:0] resume_o,
	output l1_pkg::l2req_packet_t l2req_o,
	input l2req_ready_i,
	input l1_pkg::l2rsp_packet_t l2rsp_i);

	import l1_pkg::*;

	// Slot state and payload
	logic [STRANDS - 1:0] slot_valid;
	logic [STRANDS - 1:0] slot_sent;	// Handed to the arbiter
	line_addr_t slot_addr [STRANDS];
	line_t slot_data [STRANDS];
	mask_t slot_mask [STRANDS];

	// Issue selection
	strand_t rr_ptr;
	logic locked;			// Offered but not taken, keep it stable
	strand_t lock_strand;
	logic pick_valid;
	strand_t pick_strand;
	strand_t issue_strand;
	logic issue_valid;
	logic rsp_match;

	// Load side
	logic load_r;
	line_addr_t load_addr_r;
	strand_t load_strand_r;
	logic bypass;

	// Round robin starting at rr_ptr, lowest offset wins
	always_comb
	begin
		strand_t idx;

		pick_valid = 1'b0;
		pick_strand = rr_ptr;
		for (int i = STRANDS - 1; i >= 0; i--)
		begin
			idx = rr_ptr + strand_t'(i);
			if (slot_valid[idx] && !slot_sent[idx])
			begin
				pick_valid = 1'b1;
				pick_strand = idx;
			end
		end
	end

	assign issue_valid = locked || pick_valid;
	assign issue_strand = locked ? lock_strand : pick_strand;

	always_comb
	begin
		l2req_o.valid = issue_valid;
		l2req_o.op = L2_STORE;
		l2req_o.unit = UNIT_STBUF;
		l2req_o.strand = issue_strand;
		l2req_o.address = slot_addr[issue_strand];
		l2req_o.mask = slot_mask[issue_strand];
		l2req_o.data = slot_data[issue_strand];
	end

	assign rsp_match = l2rsp_i.valid && l2rsp_i.op == L2_STORE && l2rsp_i.unit == UNIT_STBUF
		&& slot_sent[l2rsp_i.strand];

	// Pending store of the same strand and line overlays the cache line
	assign bypass = load_r && slot_valid[load_strand_r] && slot_addr[load_strand_r] == load_addr_r;

	always_comb
	begin
		data_o = cache_data_i;
		for (int b = 0; b < LINE_BYTES; b++)
		begin
			if (bypass && slot_mask[load_strand_r][b])
				data_o[b * 8 +: 8] = slot_data[load_strand_r][b * 8 +: 8];
		end
	end

	always_ff @(posedge clk)
	begin
		load_addr_r <= addr_i;
		load_strand_r <= strand_i;
		if (issue_valid && !locked)
			lock_strand <= pick_strand;
		if (store_i && !slot_valid[strand_i])
		begin
			slot_addr[strand_i] <= addr_i;
			slot_data[strand_i] <= data_i;
			slot_mask[strand_i] <= mask_i;
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			slot_valid <= '0;
			slot_sent <= '0;
			rr_ptr <= '0;
			locked <= 1'b0;
			load_r <= 1'b0;
			rollback_o <= 1'b0;
			resume_o <= '0;
		end
		else
		begin
			load_r <= load_i;
			rollback_o <= store_i && slot_valid[strand_i];	// Full slot, store dropped
			resume_o <= '0;

			if (issue_valid && l2req_ready_i)
			begin
				slot_sent[issue_strand] <= 1'b1;
				rr_ptr <= issue_strand + 1'b1;
				locked <= 1'b0;
			end
			else if (issue_valid)
				locked <= 1'b1;

			if (rsp_match)
			begin
				slot_valid[l2rsp_i.strand] <= 1'b0;
				slot_sent[l2rsp_i.strand] <= 1'b0;
				resume_o[l2rsp_i.strand] <= 1'b1;
			end

			if (store_i && !slot_valid[strand_i])
				slot_valid[strand_i] <= 1'b1;
		end
	end
endmodule
